// File: dhcp_pkg.sv
package dhcp_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [31:0] ipv4_t;
  typedef logic [31:0] xid_t;
  typedef logic [47:0] mac_addr_t;

  ////////////////////////////////////////
  // option codes
  ////////////////////////////////////////
  localparam byte_t OPT_PAD         = 8'd0;
  localparam byte_t OPT_SUBNET_MASK = 8'd1;
  localparam byte_t OPT_ROUTER      = 8'd3;
  localparam byte_t OPT_REQ_IP      = 8'd50;
  localparam byte_t OPT_MSG_TYPE    = 8'd53;
  localparam byte_t OPT_SERVER_ID   = 8'd54;
  localparam byte_t OPT_CLIENT_ID   = 8'd61;
  localparam byte_t OPT_END         = 8'd255;
  localparam byte_t CLIENT_ID_LEN   = 8'd7; // htype byte + mac

  localparam byte_t MSG_DISCOVER    = 8'd1;
  localparam byte_t MSG_OFFER       = 8'd2;
  localparam byte_t MSG_REQUEST     = 8'd3;
  localparam byte_t MSG_ACK         = 8'd5;

  localparam byte_t OP_BOOT_REQUEST = 8'd1;
  localparam byte_t OP_BOOT_REPLY   = 8'd2;

  ////////////////////////////////////////
  // bootp header layout
  ////////////////////////////////////////
  localparam int          HDR_LEN     = 240; // fixed part plus magic cookie
  localparam logic [31:0] DHCP_COOKIE = 32'h6382_5363;
  localparam int          OFS_XID     = 4;
  localparam int          OFS_FLAGS   = 10;
  localparam int          OFS_YIADDR  = 16;
  localparam int          OFS_SIADDR  = 20;
  localparam int          OFS_CHADDR  = 28;
  localparam int          OFS_COOKIE  = 236;

  // what the framer needs to build one frame
  typedef struct packed {
    byte_t msg_type;
    xid_t  xid;
    ipv4_t req_ip;
    ipv4_t server_id;
    logic  server_id_pres;
  } tx_msg_t;

  typedef struct packed {
    byte_t op;
    xid_t  xid;
    ipv4_t yiaddr;
    ipv4_t siaddr;
    byte_t msg_type;
    logic  msg_type_pres;
    ipv4_t subnet_mask;
    logic  subnet_mask_pres;
    ipv4_t router;
    logic  router_pres;
  } rx_msg_t;

  typedef struct packed {
    ipv4_t ipv4;
    ipv4_t router;
    logic  router_val;
    ipv4_t subnet_mask;
    logic  subnet_mask_val;
  } lease_t;

  typedef enum logic [2:0] {
    idle_s,
    discover_s,
    offer_wait_s,
    request_s,
    ack_wait_s
  } client_state_e;

endpackage

// File: dhcp_rx_parser.sv
`timescale 1ns/100ps

module dhcp_rx_parser (
  input  logic              clk,
  input  logic              fsm_rst,
  input  logic              rx_val,
  input  logic              rx_sof,
  input  logic              rx_eof,
  input  dhcp_pkg::byte_t   rx_dat,
  output dhcp_pkg::rx_msg_t rx_msg,
  output logic              rx_msg_val
);

  typedef enum logic [1:0] {kind_f, len_f, data_f} field_e;

  field_e          field;
  logic            active;   // inside an accepted frame
  logic            in_opts;  // header done, cookie good
  logic [7:0]      byte_cnt;
  logic [7:0]      pos;
  logic [23:0]     shift_q;  // previous three bytes
  logic [31:0]     word;
  dhcp_pkg::byte_t opt_code;
  dhcp_pkg::byte_t opt_len;
  dhcp_pkg::byte_t opt_cnt;

  assign pos  = rx_sof ? 8'd0 : byte_cnt;
  assign word = {shift_q, rx_dat};

  always_ff @(posedge clk) begin
    rx_msg_val <= 1'b0;
    if (fsm_rst) begin
      active                  <= 1'b0;
      in_opts                 <= 1'b0;
      field                   <= kind_f;
      byte_cnt                <= '0;
      rx_msg.msg_type_pres    <= 1'b0;
      rx_msg.subnet_mask_pres <= 1'b0;
      rx_msg.router_pres      <= 1'b0;
    end else if (rx_val && (rx_sof || active)) begin
      shift_q <= word[23:0];
      if (rx_sof) begin
        active                  <= 1'b1;
        in_opts                 <= 1'b0;
        field                   <= kind_f;
        rx_msg.msg_type         <= '0;
        rx_msg.msg_type_pres    <= 1'b0;
        rx_msg.subnet_mask      <= '0;
        rx_msg.subnet_mask_pres <= 1'b0;
        rx_msg.router           <= '0;
        rx_msg.router_pres      <= 1'b0;
      end
      if (rx_sof || !in_opts) begin
        byte_cnt <= pos + 8'd1;
        if (pos == 8'd0) rx_msg.op <= rx_dat;
        if (pos == 8'(dhcp_pkg::OFS_XID + 3)) rx_msg.xid <= word;
        if (pos == 8'(dhcp_pkg::OFS_YIADDR + 3)) rx_msg.yiaddr <= word;
        if (pos == 8'(dhcp_pkg::OFS_SIADDR + 3)) rx_msg.siaddr <= word;
        if (pos == 8'(dhcp_pkg::HDR_LEN - 1)) begin // last cookie byte
          in_opts <= (word == dhcp_pkg::DHCP_COOKIE);
          active  <= (word == dhcp_pkg::DHCP_COOKIE);
        end
      end else begin
        case (field)
          kind_f: begin
            opt_code <= rx_dat;
            if (rx_dat == dhcp_pkg::OPT_END) begin
              rx_msg_val <= 1'b1;
              active     <= 1'b0;
            end else if (rx_dat != dhcp_pkg::OPT_PAD) begin
              field <= len_f;
            end
          end
          len_f: begin
            opt_len <= rx_dat;
            opt_cnt <= '0;
            field   <= (rx_dat == 8'd0) ? kind_f : data_f;
          end
          data_f: begin
            opt_cnt <= opt_cnt + 8'd1;
            if (opt_cnt == opt_len - 8'd1) begin
              field <= kind_f;
              case (opt_code)
                dhcp_pkg::OPT_MSG_TYPE: begin
                  rx_msg.msg_type      <= rx_dat;
                  rx_msg.msg_type_pres <= 1'b1;
                end
                dhcp_pkg::OPT_SUBNET_MASK: begin
                  rx_msg.subnet_mask      <= word;
                  rx_msg.subnet_mask_pres <= 1'b1;
                end
                dhcp_pkg::OPT_ROUTER: begin
                  rx_msg.router      <= word; // last 4 bytes of the list
                  rx_msg.router_pres <= 1'b1;
                end
                default: ; // skipped by length
              endcase
            end
          end
          default: field <= kind_f;
        endcase
      end
      if (rx_eof) active <= 1'b0; // frame over, end option or not
    end
  end

  // one message per frame, never back to back
  assert property (@(posedge clk) disable iff (fsm_rst) rx_msg_val |=> !rx_msg_val);

endmodule

// File: dhcp_client_fsm.sv
`timescale 1ns/100ps

module dhcp_client_fsm #(
  parameter int TIMEOUT = 1000000,
  parameter int RETRIES = 3
) (
  input  logic              clk,
  input  logic              fsm_rst,
  input  logic              start,
  input  dhcp_pkg::ipv4_t   preferred_ipv4,
  input  dhcp_pkg::rx_msg_t rx_msg,
  input  logic              rx_msg_val,
  input  logic              tx_busy,
  output dhcp_pkg::tx_msg_t tx_msg,
  output logic              tx_start,
  output logic              success,
  output logic              fail,
  output dhcp_pkg::lease_t  lease
);

  localparam int TMR_W = $clog2(TIMEOUT + 1);
  localparam int TRY_W = $clog2(RETRIES + 1);

  dhcp_pkg::client_state_e state;
  logic [TMR_W-1:0]        timer;
  logic [TRY_W-1:0]        try_cnt;
  logic [31:0]             lfsr;
  dhcp_pkg::xid_t          xid;
  dhcp_pkg::ipv4_t         offer_ip;
  dhcp_pkg::ipv4_t         server_ip;
  logic                    in_wait;
  logic                    reply_hit;
  logic                    timed_out;

  function automatic logic reply_ok(dhcp_pkg::rx_msg_t m, dhcp_pkg::xid_t x,
                                    dhcp_pkg::byte_t t);
    return m.op == dhcp_pkg::OP_BOOT_REPLY && m.xid == x && m.msg_type_pres &&
           m.msg_type == t;
  endfunction

  assign in_wait   = (state == dhcp_pkg::offer_wait_s) || (state == dhcp_pkg::ack_wait_s);
  assign timed_out = (timer == TMR_W'(TIMEOUT - 1));
  assign reply_hit = rx_msg_val && reply_ok(rx_msg, xid, (state == dhcp_pkg::offer_wait_s) ?
                     dhcp_pkg::MSG_OFFER : dhcp_pkg::MSG_ACK);

  // x^32 + x^22 + x^2 + x + 1
  always_ff @(posedge clk) begin
    if (fsm_rst)
      lfsr <= 32'hace1_2468;
    else
      lfsr <= {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
  end

  always_ff @(posedge clk) begin
    tx_start <= 1'b0;
    if (fsm_rst) begin
      state                 <= dhcp_pkg::idle_s;
      timer                 <= '0;
      try_cnt               <= '0;
      success               <= 1'b0;
      fail                  <= 1'b0;
      lease.router_val      <= 1'b0;
      lease.subnet_mask_val <= 1'b0;
    end else if (start && (state == dhcp_pkg::idle_s || fail)) begin
      try_cnt <= '0;
      success <= 1'b0;
      fail    <= 1'b0;
      lease   <= '0;
      state   <= dhcp_pkg::discover_s;
    end else begin
      case (state)
        dhcp_pkg::discover_s: begin
          xid      <= lfsr;
          tx_msg   <= '{msg_type: dhcp_pkg::MSG_DISCOVER, xid: lfsr, req_ip: preferred_ipv4,
                        server_id: '0, server_id_pres: 1'b0};
          tx_start <= 1'b1;
          timer    <= '0;
          state    <= dhcp_pkg::offer_wait_s;
        end
        dhcp_pkg::offer_wait_s: if (reply_hit) begin
          offer_ip  <= rx_msg.yiaddr;
          server_ip <= rx_msg.siaddr;
          state     <= dhcp_pkg::request_s;
        end
        dhcp_pkg::request_s: begin
          tx_msg   <= '{msg_type: dhcp_pkg::MSG_REQUEST, xid: xid, req_ip: offer_ip,
                        server_id: server_ip, server_id_pres: 1'b1};
          tx_start <= 1'b1;
          timer    <= '0;
          state    <= dhcp_pkg::ack_wait_s;
        end
        dhcp_pkg::ack_wait_s: if (reply_hit) begin
          success <= 1'b1;
          lease   <= '{ipv4: rx_msg.yiaddr, router: rx_msg.router,
                       router_val: rx_msg.router_pres, subnet_mask: rx_msg.subnet_mask,
                       subnet_mask_val: rx_msg.subnet_mask_pres};
          state   <= dhcp_pkg::idle_s;
        end
        default: ;
      endcase
      if (in_wait && !reply_hit) begin
        timer <= timer + 1'b1;
        if (timed_out) begin
          if (try_cnt == TRY_W'(RETRIES)) begin // out of retries
            fail  <= 1'b1;
            state <= dhcp_pkg::idle_s;
          end else begin
            try_cnt <= try_cnt + 1'b1;
            state   <= dhcp_pkg::discover_s;
          end
        end
      end
    end
  end

  // framer must have finished the previous frame
  assert property (@(posedge clk) disable iff (fsm_rst) tx_start |-> !tx_busy);
  assert property (@(posedge clk) disable iff (fsm_rst) !(success && fail));

endmodule

// File: dhcp_tx_framer.sv
`timescale 1ns/100ps

module dhcp_tx_framer #(
  parameter dhcp_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic              clk,
  input  logic              fsm_rst,
  input  logic              tx_start,
  input  dhcp_pkg::tx_msg_t tx_msg,
  input  logic              tx_req,
  output logic              tx_rdy,
  output logic              tx_val,
  output logic              tx_sof,
  output logic              tx_eof,
  output dhcp_pkg::byte_t   tx_dat,
  output logic              tx_busy
);

  localparam int OPT_LEN = 3 + 6 + 9 + 1; // msg type, req ip, client id, end

  logic [8:0]      byte_cnt;
  logic [8:0]      opt_ofs;
  logic [8:0]      last_byte;
  dhcp_pkg::byte_t next_dat;

  // byte k of an n-byte big endian field
  function automatic dhcp_pkg::byte_t pick(logic [47:0] v, int n, int k);
    return v[8*(n-1-k) +: 8];
  endfunction

  assign opt_ofs   = byte_cnt - 9'(dhcp_pkg::HDR_LEN);
  assign last_byte = 9'(dhcp_pkg::HDR_LEN + OPT_LEN - 1) + (tx_msg.server_id_pres ? 9'd6 : 9'd0);
  assign tx_busy   = tx_rdy;

  ////////////////////////////////////////
  // byte generator
  ////////////////////////////////////////
  always_comb begin
    next_dat = 8'h00;
    if (byte_cnt < 9'(dhcp_pkg::HDR_LEN)) begin
      case (byte_cnt) inside
        9'd0: next_dat = dhcp_pkg::OP_BOOT_REQUEST;
        9'd1: next_dat = 8'd1; // htype ethernet
        9'd2: next_dat = 8'd6; // hlen
        [dhcp_pkg::OFS_XID:dhcp_pkg::OFS_XID+3]:
          next_dat = pick(48'(tx_msg.xid), 4, byte_cnt - dhcp_pkg::OFS_XID);
        dhcp_pkg::OFS_FLAGS: next_dat = 8'h80; // broadcast
        [dhcp_pkg::OFS_CHADDR:dhcp_pkg::OFS_CHADDR+5]:
          next_dat = pick(MAC_ADDR, 6, byte_cnt - dhcp_pkg::OFS_CHADDR);
        [dhcp_pkg::OFS_COOKIE:dhcp_pkg::OFS_COOKIE+3]:
          next_dat = pick(48'(dhcp_pkg::DHCP_COOKIE), 4, byte_cnt - dhcp_pkg::OFS_COOKIE);
        default: next_dat = 8'h00;
      endcase
    end else begin
      case (opt_ofs) inside
        0:       next_dat = dhcp_pkg::OPT_MSG_TYPE;
        1:       next_dat = 8'd1;
        2:       next_dat = tx_msg.msg_type;
        3:       next_dat = dhcp_pkg::OPT_REQ_IP;
        4:       next_dat = 8'd4;
        [5:8]:   next_dat = pick(48'(tx_msg.req_ip), 4, opt_ofs - 5);
        9:       next_dat = dhcp_pkg::OPT_CLIENT_ID;
        10:      next_dat = dhcp_pkg::CLIENT_ID_LEN;
        11:      next_dat = 8'd1;
        [12:17]: next_dat = pick(MAC_ADDR, 6, opt_ofs - 12);
        18:      next_dat = tx_msg.server_id_pres ? dhcp_pkg::OPT_SERVER_ID : dhcp_pkg::OPT_END;
        19:      next_dat = 8'd4;
        [20:23]: next_dat = pick(48'(tx_msg.server_id), 4, opt_ofs - 20);
        default: next_dat = dhcp_pkg::OPT_END;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      tx_rdy   <= 1'b0;
      tx_val   <= 1'b0;
      tx_sof   <= 1'b0;
      tx_eof   <= 1'b0;
      byte_cnt <= '0;
    end else begin
      tx_val <= 1'b0;
      tx_sof <= 1'b0;
      tx_eof <= 1'b0;
      if (tx_start) begin
        tx_rdy   <= 1'b1;
        byte_cnt <= '0;
      end else if (tx_rdy && tx_req) begin
        tx_val   <= 1'b1;
        tx_dat   <= next_dat;
        tx_sof   <= (byte_cnt == 9'd0);
        tx_eof   <= (byte_cnt == last_byte);
        byte_cnt <= byte_cnt + 9'd1;
        if (byte_cnt == last_byte) tx_rdy <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk) disable iff (fsm_rst) tx_val |-> $past(tx_rdy));

endmodule

// File: dhcp_client.sv
`timescale 1ns/100ps

module dhcp_client #(
  parameter dhcp_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01,
  parameter int                  TIMEOUT  = 1000000, // cycles per wait state
  parameter int                  RETRIES  = 3
) (
  input  logic             clk,
  input  logic             fsm_rst,
  input  logic             rx_val,
  input  logic             rx_sof,
  input  logic             rx_eof,
  input  dhcp_pkg::byte_t  rx_dat,
  input  logic             start,
  input  dhcp_pkg::ipv4_t  preferred_ipv4,
  input  logic             tx_req,
  output logic             tx_rdy,
  output logic             tx_val,
  output logic             tx_sof,
  output logic             tx_eof,
  output dhcp_pkg::byte_t  tx_dat,
  output logic             success,
  output logic             fail,
  output dhcp_pkg::lease_t lease
);

  dhcp_pkg::rx_msg_t rx_msg;
  dhcp_pkg::tx_msg_t tx_msg;
  logic              rx_msg_val;
  logic              tx_start;
  logic              tx_busy;

  dhcp_rx_parser u_rx_parser (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .rx_val     (rx_val),
    .rx_sof     (rx_sof),
    .rx_eof     (rx_eof),
    .rx_dat     (rx_dat),
    .rx_msg     (rx_msg),
    .rx_msg_val (rx_msg_val)
  );

  dhcp_client_fsm #(
    .TIMEOUT (TIMEOUT),
    .RETRIES (RETRIES)
  ) u_client_fsm (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .start          (start),
    .preferred_ipv4 (preferred_ipv4),
    .rx_msg         (rx_msg),
    .rx_msg_val     (rx_msg_val),
    .tx_busy        (tx_busy),
    .tx_msg         (tx_msg),
    .tx_start       (tx_start),
    .success        (success),
    .fail           (fail),
    .lease          (lease)
  );

  dhcp_tx_framer #(
    .MAC_ADDR (MAC_ADDR)
  ) u_tx_framer (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .tx_start (tx_start),
    .tx_msg   (tx_msg),
    .tx_req   (tx_req),
    .tx_rdy   (tx_rdy),
    .tx_val   (tx_val),
    .tx_sof   (tx_sof),
    .tx_eof   (tx_eof),
    .tx_dat   (tx_dat),
    .tx_busy  (tx_busy)
  );

endmodule

// File: tb_dhcp_client.sv
`timescale 1ns/100ps

module tb_dhcp_client;

  localparam dhcp_pkg::mac_addr_t TB_MAC = 48'h02_1a_2b_3c_4d_5e;
  localparam int TIMEOUT    = 3000;
  localparam int RETRIES    = 2;
  localparam int CLK_PERIOD = 100;
  localparam int FRAME_CYC  = 2 * 265; // worst case frame with gaps
  localparam int IDLE_CYC   = 200;
  // 8 sent frames, 8 replies, the retry waits and the quiet checks
  localparam int LIMIT_CYC  = 16 * FRAME_CYC + (RETRIES + 1) * TIMEOUT + 4 * IDLE_CYC + 2000;

  logic                clk = 1'b0;
  logic                fsm_rst;
  logic                rx_val;
  logic                rx_sof;
  logic                rx_eof;
  dhcp_pkg::byte_t     rx_dat;
  logic                start;
  dhcp_pkg::ipv4_t     preferred_ipv4;
  logic                tx_req;
  logic                tx_rdy;
  logic                tx_val;
  logic                tx_sof;
  logic                tx_eof;
  dhcp_pkg::byte_t     tx_dat;
  logic                success;
  logic                fail;
  dhcp_pkg::lease_t    lease;

  dhcp_pkg::byte_t     tx_frame[$];  // bytes of the frame being sent
  dhcp_pkg::byte_t     reply_q[$];   // server reply under construction
  int                  sof_cnt = 0;
  int                  sof_pos = 0;
  int                  checked_cnt = 0;
  dhcp_pkg::xid_t      kept_xid = '0;
  dhcp_pkg::byte_t     exp_type;
  dhcp_pkg::ipv4_t     exp_req_ip;
  dhcp_pkg::ipv4_t     exp_sid;
  logic                exp_sid_pres;
  logic                gap_pat[1024];
  logic [9:0]          req_idx = '0;
  logic                gaps_on = 1'b0;
  event                frame_done;

  dhcp_client #(
    .MAC_ADDR (TB_MAC),
    .TIMEOUT  (TIMEOUT),
    .RETRIES  (RETRIES)
  ) u_dhcp_client (
    .clk            (clk),
    .fsm_rst        (fsm_rst),
    .rx_val         (rx_val),
    .rx_sof         (rx_sof),
    .rx_eof         (rx_eof),
    .rx_dat         (rx_dat),
    .start          (start),
    .preferred_ipv4 (preferred_ipv4),
    .tx_req         (tx_req),
    .tx_rdy         (tx_rdy),
    .tx_val         (tx_val),
    .tx_sof         (tx_sof),
    .tx_eof         (tx_eof),
    .tx_dat         (tx_dat),
    .success        (success),
    .fail           (fail),
    .lease          (lease)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_mismatch(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopping on first error");
  endtask

  ////////////////////////////////////////
  // expected frame, byte by byte
  ////////////////////////////////////////
  function automatic dhcp_pkg::byte_t ref_byte(input int i, input dhcp_pkg::byte_t mt,
                                               input dhcp_pkg::xid_t x,
                                               input dhcp_pkg::ipv4_t rip,
                                               input dhcp_pkg::ipv4_t sid, input logic pres);
    dhcp_pkg::byte_t opt[25];
    opt = '{default: 8'h00};
    if (i < 240) begin
      if (i == 0 || i == 1) return 8'd1; // bootrequest, ethernet
      if (i == 2) return 8'd6;
      if (i >= 4 && i <= 7) return 8'(x >> (8 * (7 - i)));
      if (i == 10) return 8'h80;
      if (i >= 28 && i <= 33) return 8'(TB_MAC >> (8 * (33 - i)));
      if (i >= 236) return 8'(32'h6382_5363 >> (8 * (239 - i)));
      return 8'h00;
    end
    opt[0]  = 8'd53;
    opt[1]  = 8'd1;
    opt[2]  = mt;
    opt[3]  = 8'd50;
    opt[4]  = 8'd4;
    opt[9]  = 8'd61;
    opt[10] = 8'd7;
    opt[11] = 8'd1;
    for (int k = 0; k < 4; k++) opt[5 + k] = 8'(rip >> (24 - 8 * k));
    for (int k = 0; k < 6; k++) opt[12 + k] = 8'(TB_MAC >> (40 - 8 * k));
    opt[18] = 8'd255;
    if (pres) begin
      opt[18] = 8'd54;
      opt[19] = 8'd4;
      for (int k = 0; k < 4; k++) opt[20 + k] = 8'(sid >> (24 - 8 * k));
      opt[24] = 8'd255;
    end
    return opt[i - 240];
  endfunction

  // back-pressure from a fixed random pattern
  always @(negedge clk) begin
    tx_req  = gaps_on ? gap_pat[req_idx] : 1'b1;
    req_idx = req_idx + 10'd1;
  end

  // frame collector
  always @(negedge clk) begin
    if (!fsm_rst && tx_val) begin
      if (tx_sof) begin
        sof_cnt = sof_cnt + 1;
        sof_pos = tx_frame.size();
      end
      tx_frame.push_back(tx_dat);
      if (tx_eof) -> frame_done;
    end
  end

  always @(frame_done) begin : compare_frame
    dhcp_pkg::xid_t  x;
    dhcp_pkg::byte_t exp_b;
    int              len;
    len = exp_sid_pres ? 265 : 259;
    assert (tx_frame.size() == len)
      else report_mismatch($sformatf("frame length %0d, expected %0d", tx_frame.size(), len));
    assert (sof_cnt == 1 && sof_pos == 0)
      else report_mismatch("tx_sof missing, repeated or not on the first byte");
    x = {tx_frame[4], tx_frame[5], tx_frame[6], tx_frame[7]};
    if (exp_type == dhcp_pkg::MSG_DISCOVER) begin
      assert (x != kept_xid) else report_mismatch("discover reuses the previous xid");
      kept_xid = x;
    end
    for (int i = 0; i < len; i++) begin
      exp_b = ref_byte(i, exp_type, kept_xid, exp_req_ip, exp_sid, exp_sid_pres);
      assert (tx_frame[i] == exp_b)
        else report_mismatch($sformatf("frame %0d byte %0d is %02h, expected %02h",
                                       checked_cnt, i, tx_frame[i], exp_b));
    end
    tx_frame.delete();
    sof_cnt     = 0;
    checked_cnt = checked_cnt + 1;
  end

  ////////////////////////////////////////
  // server model
  ////////////////////////////////////////
  task automatic push_word(input logic [31:0] w);
    for (int k = 0; k < 4; k++) reply_q.push_back(8'(w >> (24 - 8 * k)));
  endtask

  task automatic build_reply(input dhcp_pkg::xid_t x, input dhcp_pkg::byte_t mt,
                             input dhcp_pkg::ipv4_t yi, input dhcp_pkg::ipv4_t si,
                             input dhcp_pkg::ipv4_t rt, input dhcp_pkg::ipv4_t mk,
                             input logic with_router, input logic with_mask);
    int unk_len;
    reply_q.delete();
    for (int i = 0; i < 4; i++) reply_q.push_back(8'h00);
    reply_q[0] = 8'd2; // bootreply
    reply_q[1] = 8'd1;
    reply_q[2] = 8'd6;
    push_word(x);
    for (int i = 8; i < 16; i++) reply_q.push_back(8'h00);
    push_word(yi);
    push_word(si);
    for (int i = 24; i < 236; i++) reply_q.push_back(8'h00);
    push_word(32'h6382_5363);
    reply_q.push_back(8'd53);
    reply_q.push_back(8'd1);
    reply_q.push_back(mt);
    unk_len = 1 + ($urandom % 6);
    reply_q.push_back(8'(100 + ($urandom % 100))); // option the client does not use
    reply_q.push_back(8'(unk_len));
    for (int i = 0; i < unk_len; i++) reply_q.push_back(8'($urandom));
    reply_q.push_back(8'd0); // pad
    if (with_router) begin
      reply_q.push_back(8'd3);
      reply_q.push_back(8'd4);
      push_word(rt);
    end
    if (with_mask) begin
      reply_q.push_back(8'd1);
      reply_q.push_back(8'd4);
      push_word(mk);
    end
    reply_q.push_back(8'd255);
  endtask

  task automatic send_reply;
    for (int i = 0; i < reply_q.size(); i++) begin
      while ($urandom % 8 == 0) begin // idle gap
        rx_val = 1'b0;
        rx_sof = 1'b0;
        rx_eof = 1'b0;
        @(negedge clk);
      end
      rx_val = 1'b1;
      rx_sof = (i == 0);
      rx_eof = (i == reply_q.size() - 1);
      rx_dat = reply_q[i];
      @(negedge clk);
    end
    rx_val = 1'b0;
    rx_sof = 1'b0;
    rx_eof = 1'b0;
  endtask

  task automatic pulse_start;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_frames(input int n);
    while (checked_cnt < n) @(negedge clk);
  endtask

  // nothing sent, no success, while a reply is ignored
  task automatic check_quiet(input int n);
    repeat (IDLE_CYC) @(negedge clk);
    assert (checked_cnt == n && !tx_rdy && !success)
      else report_mismatch("client reacted to a reply it should ignore");
  endtask

  task automatic run_exchange(input logic with_mask);
    dhcp_pkg::ipv4_t yi;
    dhcp_pkg::ipv4_t si;
    dhcp_pkg::ipv4_t rt;
    dhcp_pkg::ipv4_t mk;
    int              n;
    yi = $urandom;
    si = $urandom;
    rt = $urandom;
    mk = $urandom;
    n  = checked_cnt;
    preferred_ipv4 = $urandom;
    exp_type     = dhcp_pkg::MSG_DISCOVER;
    exp_req_ip   = preferred_ipv4;
    exp_sid      = '0;
    exp_sid_pres = 1'b0;
    pulse_start();
    wait_frames(n + 1);
    gaps_on = 1'b1;
    build_reply(kept_xid ^ 32'h0000_0100, dhcp_pkg::MSG_OFFER, yi, si, rt, mk, 1'b0, 1'b0);
    send_reply();
    check_quiet(n + 1);
    exp_type     = dhcp_pkg::MSG_REQUEST;
    exp_req_ip   = yi;
    exp_sid      = si;
    exp_sid_pres = 1'b1;
    build_reply(kept_xid, dhcp_pkg::MSG_OFFER, yi, si, rt, mk, 1'b0, 1'b0);
    send_reply();
    wait_frames(n + 2);
    build_reply(kept_xid, dhcp_pkg::MSG_OFFER, yi, si, rt, mk, 1'b0, 1'b0); // stale offer
    send_reply();
    check_quiet(n + 2);
    build_reply(kept_xid, dhcp_pkg::MSG_ACK, yi, si, rt, mk, 1'b1, with_mask);
    send_reply();
    while (!success) @(negedge clk);
    assert (lease.ipv4 == yi && lease.router == rt && lease.router_val)
      else report_mismatch($sformatf("lease ip %08h router %08h, expected %08h %08h",
                                     lease.ipv4, lease.router, yi, rt));
    assert (lease.subnet_mask_val == with_mask && (!with_mask || lease.subnet_mask == mk))
      else report_mismatch("subnet mask or its valid flag wrong in the lease");
    assert (!fail) else report_mismatch("fail high together with success");
  endtask

  initial begin : watchdog
    #(longint'(LIMIT_CYC) * CLK_PERIOD);
    $display("ERROR: watchdog expired, the client never finished the exchange");
    $display("TEST RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin : main
    int n;
    void'($urandom(48246));
    for (int i = 0; i < 1024; i++) gap_pat[i] = ($urandom % 4) != 0;
    fsm_rst        = 1'b1;
    rx_val         = 1'b0;
    rx_sof         = 1'b0;
    rx_eof         = 1'b0;
    rx_dat         = '0;
    start          = 1'b0;
    preferred_ipv4 = '0;
    tx_req         = 1'b0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    assert (!tx_rdy && !tx_val && !tx_sof && !tx_eof && !success && !fail &&
            !lease.router_val && !lease.subnet_mask_val)
      else report_mismatch("outputs not low after reset");

    run_exchange(1'b0); // router only
    run_exchange(1'b1); // router and mask

    // no server at all
    n = checked_cnt;
    preferred_ipv4 = $urandom;
    exp_type     = dhcp_pkg::MSG_DISCOVER;
    exp_req_ip   = preferred_ipv4;
    exp_sid_pres = 1'b0;
    pulse_start();
    while (!fail) @(negedge clk);
    assert (checked_cnt == n + RETRIES + 1 && !success)
      else report_mismatch($sformatf("%0d discovers before fail, expected %0d",
                                     checked_cnt - n, RETRIES + 1));
    pulse_start();
    assert (!fail) else report_mismatch("start did not clear fail");
    wait_frames(n + RETRIES + 2);

    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// File: compile.f
dhcp_pkg.sv
dhcp_rx_parser.sv
dhcp_client_fsm.sv
dhcp_tx_framer.sv
dhcp_client.sv
tb_dhcp_client.sv

// File: run.sh
#!/bin/sh
# build and run the DHCP client testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_dhcp_client \
  -f compile.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
